// ==== c16_mem_pkg.sv ====
/* memory map of the C16 glue; RAM sits at SDRAM byte 0, ROM and TAP images above it
   all addresses assume a single 16-bit wide SDRAM port */
package c16_mem_pkg;

	// byte address as seen by downloads and the tape player
	typedef logic [24:0] dl_addr_t;
	// address of a 16-bit word in the SDRAM
	typedef logic [23:0] word_addr_t;
	// C16 CPU address
	typedef logic [15:0] cpu_addr_t;
	// 00 Kernal, 01 BASIC, 10 Function LOW, 11 Function HIGH
	typedef logic [1:0]  rom_bank_t;

	// --------------------------------------------------------------------------
	// image locations
	// --------------------------------------------------------------------------
	localparam dl_addr_t ROM_MEM_START = 25'h10000;
	localparam dl_addr_t TAP_MEM_START = 25'h20000;

	// word address bit that marks the ROM space
	localparam int ROM_WORD_FLAG = 15;

	// low bytes of the BASIC pointers, the high byte follows each one
	localparam cpu_addr_t ZP_PTR_ADDR [4] = '{
		16'h002d,
		16'h002f,
		16'h0031,
		16'h009d
	};

endpackage

// ==== c16_io_pkg.sv ====
/* download kinds and timing constants of the I/O controller side
   index values follow the I/O controller menu */
package c16_io_pkg;

	// --------------------------------------------------------------------------
	// download indices
	// --------------------------------------------------------------------------
	localparam logic [7:0] IDX_ROM0 = 8'h00;
	localparam logic [7:0] IDX_PRG  = 8'h01;
	localparam logic [7:0] IDX_ROM3 = 8'h03;
	localparam logic [7:0] IDX_TAP  = 8'h41;

	// reset lengths in clk28 cycles
	localparam int unsigned RESET_LONG_DEFAULT  = 28000000;
	localparam int unsigned RESET_SHORT_DEFAULT = 65536;

	// version byte inside a TAP header
	localparam logic [24:0] TAP_VERSION_OFFSET = 25'h0C;

	// an index 0 image starts with 16k of drive ROM which is not stored
	localparam logic [24:0] ROM0_SKIP = 25'h4000;

endpackage

// ==== c16_bus_if.sv ====
/* decoded C16 memory access; cpu_addr is only complete one cycle after the CAS fall */
interface c16_bus_if import c16_mem_pkg::*; ();

	cpu_addr_t   cpu_addr;
	logic        rom_access;
	rom_bank_t   rom_bank;
	logic [13:0] rom_addr;
	logic        cas_n;
	logic        rw;
	logic [7:0]  dout;
	// high in the C16 slice, low in the I/O slice
	logic        clkref;

	modport src (
		output cpu_addr,
		output rom_access,
		output rom_bank,
		output rom_addr,
		output cas_n,
		output rw,
		output dout,
		output clkref
	);

	modport sink (
		input cpu_addr,
		input rom_access,
		input rom_bank,
		input rom_addr,
		input cas_n,
		input rw,
		input dout,
		input clkref
	);

endinterface

// ==== dl_if.sv ====
/* download write path; wr_req only lives for one I/O slice */
interface dl_if import c16_mem_pkg::*; ();

	dl_addr_t   wr_addr;
	logic [7:0] wr_data;
	logic       wr_req;
	// download kind levels
	logic       prg_active;
	logic       tap_active;
	logic       rom_active;
	// raw byte from the I/O controller, one cycle late
	logic       byte_strobe;
	logic [7:0] byte_data;
	logic       prg_done;

	modport src (
		output wr_addr,
		output wr_data,
		output wr_req,
		output prg_active,
		output tap_active,
		output rom_active,
		output byte_strobe,
		output byte_data,
		output prg_done
	);

	modport sink (
		input wr_addr,
		input wr_data,
		input wr_req,
		input prg_active,
		input tap_active,
		input rom_active,
		input byte_strobe,
		input byte_data,
		input prg_done
	);

endinterface

// ==== c16_bus_decode.sv ====
/* C16 strobes must be synchronous to clk28; cartridge ROM banks read as Kernal */
module c16_bus_decode import c16_mem_pkg::*; (
	input  logic        clk28,
	input  logic        pll_locked,
	input  logic        c16_ras_i,
	input  logic        c16_cas_i,
	input  logic        c16_rw_i,
	input  logic [7:0]  c16_a_i,
	input  logic [7:0]  c16_dout_i,
	input  logic        c16_basic_sel_i,
	input  logic        c16_kernal_sel_i,
	input  logic [13:0] c16_rom_addr_i,
	input  logic [3:0]  c16_rom_sel_i,
	c16_bus_if.src      bus
);

	logic       ras_d;
	logic       cas_d;
	logic [7:0] a_low;
	logic [7:0] a_high;
	logic [3:0] clkdiv;

	// address latch and slice counter
	always_ff @(posedge clk28 or negedge pll_locked) begin
		if (!pll_locked) begin
			ras_d  <= 1'b1;
			cas_d  <= 1'b1;
			a_low  <= '0;
			a_high <= '0;
			clkdiv <= '0;
		end else begin
			ras_d <= c16_ras_i;
			cas_d <= c16_cas_i;
			if (ras_d && !c16_ras_i)
				a_low <= c16_a_i;
			if (cas_d && !c16_cas_i)
				a_high <= c16_a_i;
			// restart so that every RAS cycle sees the same slice phase
			if (ras_d && !c16_ras_i)
				clkdiv <= '0;
			else
				clkdiv <= clkdiv + 4'd1;
		end
	end

	always_comb begin
		casez ({c16_basic_sel_i, c16_rom_sel_i})
			5'b1_00??: bus.rom_bank = 2'b00;
			5'b1_10??: bus.rom_bank = 2'b11;
			5'b0_??00: bus.rom_bank = 2'b01;
			5'b0_??10: bus.rom_bank = 2'b10;
			default:   bus.rom_bank = 2'b00;
		endcase
	end

	assign bus.cpu_addr   = {a_high, a_low};
	assign bus.rom_access = (!c16_basic_sel_i || !c16_kernal_sel_i) && c16_rw_i;
	assign bus.rom_addr   = c16_rom_addr_i;
	assign bus.cas_n      = c16_cas_i;
	assign bus.rw         = c16_rw_i;
	assign bus.dout       = c16_dout_i;
	assign bus.clkref     = clkdiv[3];

endmodule

// ==== reset_gen.sv ====
/* a short reset request never shortens a long reset that is still running */
module reset_gen import c16_io_pkg::*; #(
	parameter int unsigned LONG_CYCLES  = RESET_LONG_DEFAULT,
	parameter int unsigned SHORT_CYCLES = RESET_SHORT_DEFAULT
) (
	input  logic clk28,
	input  logic pll_locked,
	input  logic io_reboot_i,
	input  logic reset_req_i,
	input  logic memory_16k_i,
	dl_if.sink   dl,
	output logic reset_o
);

	logic [31:0] reset_cnt;
	logic        last_mem16k;

	always_ff @(posedge clk28 or negedge pll_locked) begin
		if (!pll_locked) begin
			reset_cnt   <= LONG_CYCLES;
			last_mem16k <= 1'b0;
		end else begin
			last_mem16k <= memory_16k_i;
			if (io_reboot_i)
				reset_cnt <= LONG_CYCLES;
			// button, ROM download or new memory layout
			else if (reset_req_i || dl.rom_active || (memory_16k_i != last_mem16k))
				reset_cnt <= (reset_cnt > SHORT_CYCLES) ? reset_cnt : SHORT_CYCLES;
			else if (reset_cnt != 0)
				reset_cnt <= reset_cnt - 32'd1;
		end
	end

	assign reset_o = (reset_cnt != 0);

endmodule

// ==== prg_injector.sv ====
/* bytes must arrive at least one C16/I/O slice pair apart, there is no back-pressure
   a PRG image may load anywhere in the 64k, ROM and TAP images go to fixed bases */
module prg_injector import c16_mem_pkg::*, c16_io_pkg::*; (
	input  logic       clk28,
	input  logic       pll_locked,
	input  logic       ioctl_download_i,
	input  logic [7:0] ioctl_index_i,
	input  logic       ioctl_wr_i,
	input  dl_addr_t   ioctl_addr_i,
	input  logic [7:0] ioctl_data_i,
	input  logic       clkref_i,
	output logic       c16_wait_o,
	dl_if.src          dl
);

	logic       clkref_d;
	logic       ram_wr;
	logic [7:0] ram_data;
	logic       prg_d;
	logic       prg_end;
	logic       is_rom0;
	logic       is_rom3;

	assign is_rom0       = ioctl_download_i && (ioctl_index_i == IDX_ROM0);
	assign is_rom3       = ioctl_download_i && (ioctl_index_i == IDX_ROM3);
	assign dl.prg_active = ioctl_download_i && (ioctl_index_i == IDX_PRG);
	assign dl.tap_active = ioctl_download_i && (ioctl_index_i == IDX_TAP);
	assign dl.rom_active = is_rom0 || is_rom3;
	// the CPU stays off the bus while its memory is rewritten
	assign c16_wait_o    = dl.prg_active || dl.rom_active;

	always_ff @(posedge clk28 or negedge pll_locked) begin
		if (!pll_locked) begin
			clkref_d       <= 1'b0;
			ram_wr         <= 1'b0;
			ram_data       <= '0;
			prg_d          <= 1'b0;
			prg_end        <= 1'b0;
			dl.wr_addr     <= '0;
			dl.wr_data     <= '0;
			dl.wr_req      <= 1'b0;
			dl.byte_strobe <= 1'b0;
			dl.byte_data   <= '0;
			dl.prg_done    <= 1'b0;
		end else begin
			clkref_d       <= clkref_i;
			dl.byte_strobe <= ioctl_wr_i;
			if (ioctl_wr_i)
				dl.byte_data <= ioctl_data_i;
			prg_d       <= dl.prg_active;
			prg_end     <= prg_d && !dl.prg_active;
			dl.prg_done <= prg_end;

			// --------------------------------------------------------------------
			// slice sequencing
			// --------------------------------------------------------------------
			if (clkref_d && !clkref_i) begin
				dl.wr_req <= ram_wr;
				ram_wr    <= 1'b0;
				if (ram_wr)
					dl.wr_data <= ram_data;
			end
			if (!clkref_d && clkref_i) begin
				if (dl.wr_req)
					dl.wr_addr <= dl.wr_addr + 25'd1;
				dl.wr_req <= 1'b0;
			end

			// a new byte waits here for the next I/O slice
			if (ioctl_wr_i) begin
				ram_data <= ioctl_data_i;
				if (dl.prg_active) begin
					// first two bytes carry the load address
					if (ioctl_addr_i == '0)
						dl.wr_addr[7:0] <= ioctl_data_i;
					else if (ioctl_addr_i == 25'd1)
						dl.wr_addr[24:8] <= {9'd0, ioctl_data_i};
					else
						ram_wr <= 1'b1;
				end else if (dl.tap_active) begin
					if (ioctl_addr_i == '0)
						dl.wr_addr <= TAP_MEM_START;
					ram_wr <= 1'b1;
				end else if (is_rom3) begin
					if (ioctl_addr_i == '0)
						dl.wr_addr <= ROM_MEM_START;
					ram_wr <= 1'b1;
				end else if (is_rom0 && (ioctl_addr_i >= ROM0_SKIP)) begin
					if (ioctl_addr_i == ROM0_SKIP)
						dl.wr_addr <= ROM_MEM_START;
					ram_wr <= 1'b1;
				end
			end
		end
	end

endmodule

// ==== zp_shadow.sv ====
/* shadows $2d/$2f/$31/$9d; CPU writes there also reach SDRAM, reads come from here */
module zp_shadow import c16_mem_pkg::*; (
	input  logic       clk28,
	input  logic       pll_locked,
	c16_bus_if.sink    bus,
	dl_if.sink         dl,
	output logic       zp_hit_o,
	output logic [7:0] zp_data_o
);

	logic [15:0] ptr [4];
	logic [3:0]  lo_sel;
	logic [3:0]  hi_sel;
	logic        cas_d;
	logic        zp_we;

	// byte selects and read overlay
	always_comb begin
		zp_data_o = 8'hff;
		for (int i = 0; i < 4; i++) begin
			lo_sel[i] = (bus.cpu_addr == ZP_PTR_ADDR[i]);
			hi_sel[i] = (bus.cpu_addr == ZP_PTR_ADDR[i] + 16'd1);
			if (lo_sel[i])
				zp_data_o = ptr[i][7:0];
			if (hi_sel[i])
				zp_data_o = ptr[i][15:8];
		end
	end

	assign zp_hit_o = !bus.rom_access && ((lo_sel | hi_sel) != '0);

	always_ff @(posedge clk28 or negedge pll_locked) begin
		if (!pll_locked) begin
			cas_d <= 1'b1;
			zp_we <= 1'b0;
			for (int i = 0; i < 4; i++)
				ptr[i] <= '0;
		end else begin
			cas_d <= bus.cas_n;
			// one cycle after the CAS fall the high address byte is stable
			zp_we <= !bus.cas_n && cas_d;
			if (dl.prg_done) begin
				// BASIC end pointers follow the injected program
				for (int i = 0; i < 4; i++)
					ptr[i] <= dl.wr_addr[15:0] + 16'd1;
			end else if (zp_we && !bus.rw) begin
				for (int i = 0; i < 4; i++) begin
					if (lo_sel[i])
						ptr[i][7:0] <= bus.dout;
					if (hi_sel[i])
						ptr[i][15:8] <= bus.dout;
				end
			end
		end
	end

endmodule

// ==== tap_fetcher.sv ====
/* plays back the last TAP image; a full player FIFO holds the next fetch back
   no fetch runs while the I/O controller is busy */
module tap_fetcher import c16_mem_pkg::*, c16_io_pkg::*; (
	input  logic        clk28,
	input  logic        pll_locked,
	input  logic        reset_i,
	dl_if.sink          dl,
	input  logic        clkref_i,
	input  logic [15:0] sdram_dout_i,
	input  logic        tap_wrfull_i,
	input  logic        ioctl_busy_i,
	output logic        tap_oe_o,
	output dl_addr_t    tap_addr_o,
	output logic [7:0]  tap_data_o,
	output logic        tap_wrreq_o,
	output logic        tap_reset_o,
	output logic [1:0]  tap_version_o
);

	dl_addr_t last_addr;
	logic     clkref_d;

	always_ff @(posedge clk28 or negedge pll_locked) begin
		if (!pll_locked) begin
			tap_addr_o    <= TAP_MEM_START;
			last_addr     <= TAP_MEM_START;
			tap_oe_o      <= 1'b0;
			tap_data_o    <= '0;
			tap_wrreq_o   <= 1'b0;
			tap_reset_o   <= 1'b1;
			tap_version_o <= '0;
			clkref_d      <= 1'b0;
		end else if (reset_i) begin
			tap_addr_o  <= TAP_MEM_START;
			last_addr   <= TAP_MEM_START;
			tap_oe_o    <= 1'b0;
			tap_wrreq_o <= 1'b0;
			tap_reset_o <= 1'b1;
			clkref_d    <= clkref_i;
		end else begin
			clkref_d    <= clkref_i;
			tap_reset_o <= 1'b0;
			tap_wrreq_o <= 1'b0;
			// a new image rewinds the player, its write address marks the end
			if (dl.tap_active) begin
				tap_addr_o  <= TAP_MEM_START;
				last_addr   <= dl.wr_addr;
				tap_reset_o <= 1'b1;
				if (dl.byte_strobe && (dl.wr_addr == TAP_MEM_START + TAP_VERSION_OFFSET))
					tap_version_o <= dl.byte_data[1:0];
			end
			// fetch in the I/O slice
			if (clkref_d && !clkref_i && !ioctl_busy_i && !tap_wrfull_i &&
			    (tap_addr_o != last_addr))
				tap_oe_o <= 1'b1;
			// word is back by the next C16 slice
			if (!clkref_d && clkref_i && tap_oe_o) begin
				tap_wrreq_o <= 1'b1;
				tap_data_o  <= tap_addr_o[0] ? sdram_dout_i[15:8] : sdram_dout_i[7:0];
				tap_oe_o    <= 1'b0;
				tap_addr_o  <= tap_addr_o + 25'd1;
			end
		end
	end

endmodule

// ==== sdram_arbiter.sv ====
/* clkref high gives the SDRAM port to the C16, low to tape fetches and downloads */
module sdram_arbiter import c16_mem_pkg::*; (
	input  logic        memory_16k_i,
	c16_bus_if.sink     bus,
	dl_if.sink          dl,
	input  logic        tap_oe_i,
	input  dl_addr_t    tap_addr_i,
	input  logic        zp_hit_i,
	input  logic [7:0]  zp_data_i,
	input  logic [15:0] sdram_dout_i,
	output word_addr_t  sdram_addr_o,
	output logic [15:0] sdram_din_o,
	output logic        sdram_we_o,
	output logic        sdram_oe_o,
	output logic [1:0]  sdram_ds_o,
	output logic [7:0]  c16_din_o
);

	logic       tap_sel;
	dl_addr_t   byte_addr;
	cpu_addr_t  ram_byte;
	logic [14:0] ram_word;
	word_addr_t rom_word;
	logic [7:0] wr_byte;

	// a fetch never runs over an image that is still loading
	assign tap_sel = tap_oe_i && !dl.tap_active;

	always_comb begin
		if (bus.clkref)
			byte_addr = bus.rom_access ? {9'd0, bus.rom_bank, bus.rom_addr} : {9'd0, bus.cpu_addr};
		else
			byte_addr = tap_sel ? tap_addr_i : dl.wr_addr;

		// PRG downloads land in C16 RAM and follow its layout
		ram_byte = bus.clkref ? bus.cpu_addr : dl.wr_addr[15:0];
		if (memory_16k_i)
			ram_word = {1'b0, ram_byte[13:7], 1'b0, ram_byte[6:1]};
		else
			ram_word = ram_byte[15:1];

		rom_word                = '0;
		rom_word[ROM_WORD_FLAG] = 1'b1;
		rom_word[14:0]          = {bus.rom_bank, bus.rom_addr[13:1]};

		if (bus.clkref)
			sdram_addr_o = bus.rom_access ? rom_word : {9'd0, ram_word};
		else if (!tap_sel && dl.prg_active)
			sdram_addr_o = {9'd0, ram_word};
		else
			sdram_addr_o = byte_addr[24:1];
	end

	assign wr_byte     = bus.clkref ? bus.dout : dl.wr_data;
	assign sdram_din_o = {wr_byte, wr_byte};
	assign sdram_ds_o  = {byte_addr[0], !byte_addr[0]};
	assign sdram_we_o  = bus.clkref ? (!bus.cas_n && !bus.rw) : (dl.wr_req && !tap_sel);
	assign sdram_oe_o  = bus.clkref ? ((!bus.cas_n && bus.rw) || bus.rom_access) : tap_sel;

	assign c16_din_o = zp_hit_i ? zp_data_i :
		(bus.cpu_addr[0] ? sdram_dout_i[15:8] : sdram_dout_i[7:0]);

endmodule

// ==== c16_mem_glue.sv ====
/* memory glue between a C16 core and one SDRAM request port
   the SDRAM controller must finish each request within one clkref slice */
module c16_mem_glue import c16_mem_pkg::*, c16_io_pkg::*; #(
	parameter int unsigned RESET_LONG  = RESET_LONG_DEFAULT,
	parameter int unsigned RESET_SHORT = RESET_SHORT_DEFAULT
) (
	input  logic        clk28,
	input  logic        pll_locked,
	// C16 bus
	input  logic        c16_ras_i,
	input  logic        c16_cas_i,
	input  logic        c16_rw_i,
	input  logic [7:0]  c16_a_i,
	input  logic [7:0]  c16_dout_i,
	input  logic        c16_basic_sel_i,
	input  logic        c16_kernal_sel_i,
	input  logic [13:0] c16_rom_addr_i,
	input  logic [3:0]  c16_rom_sel_i,
	output logic [7:0]  c16_din_o,
	output logic        c16_wait_o,
	// I/O controller
	input  logic        ioctl_download_i,
	input  logic [7:0]  ioctl_index_i,
	input  logic        ioctl_wr_i,
	input  dl_addr_t    ioctl_addr_i,
	input  logic [7:0]  ioctl_data_i,
	input  logic        io_reboot_i,
	input  logic        reset_req_i,
	input  logic        memory_16k_i,
	// SDRAM request
	output word_addr_t  sdram_addr_o,
	output logic [15:0] sdram_din_o,
	output logic        sdram_we_o,
	output logic        sdram_oe_o,
	output logic [1:0]  sdram_ds_o,
	input  logic [15:0] sdram_dout_i,
	output logic        clkref_o,
	// cassette player
	input  logic        tap_wrfull_i,
	output logic [7:0]  tap_data_o,
	output logic        tap_wrreq_o,
	output logic        tap_reset_o,
	output logic [1:0]  tap_version_o,
	output logic        reset_o
);

	c16_bus_if bus ();
	dl_if      dl ();

	logic       tap_oe;
	dl_addr_t   tap_addr;
	logic       zp_hit;
	logic [7:0] zp_data;

	assign clkref_o = bus.clkref;

	c16_bus_decode u_decode (
		.clk28, .pll_locked, .c16_ras_i, .c16_cas_i, .c16_rw_i, .c16_a_i, .c16_dout_i,
		.c16_basic_sel_i, .c16_kernal_sel_i, .c16_rom_addr_i, .c16_rom_sel_i,
		.bus(bus.src)
	);

	reset_gen #(.LONG_CYCLES(RESET_LONG), .SHORT_CYCLES(RESET_SHORT)) u_reset (
		.clk28, .pll_locked, .io_reboot_i, .reset_req_i, .memory_16k_i,
		.dl(dl.sink), .reset_o
	);

	prg_injector u_inject (
		.clk28, .pll_locked, .ioctl_download_i, .ioctl_index_i, .ioctl_wr_i,
		.ioctl_addr_i, .ioctl_data_i, .clkref_i(bus.clkref), .c16_wait_o,
		.dl(dl.src)
	);

	zp_shadow u_zp (
		.clk28, .pll_locked, .bus(bus.sink), .dl(dl.sink),
		.zp_hit_o(zp_hit), .zp_data_o(zp_data)
	);

	tap_fetcher u_tap (
		.clk28, .pll_locked, .reset_i(reset_o), .dl(dl.sink), .clkref_i(bus.clkref),
		.sdram_dout_i, .tap_wrfull_i, .ioctl_busy_i(ioctl_download_i),
		.tap_oe_o(tap_oe), .tap_addr_o(tap_addr), .tap_data_o, .tap_wrreq_o,
		.tap_reset_o, .tap_version_o
	);

	sdram_arbiter u_arb (
		.memory_16k_i, .bus(bus.sink), .dl(dl.sink), .tap_oe_i(tap_oe),
		.tap_addr_i(tap_addr), .zp_hit_i(zp_hit), .zp_data_i(zp_data), .sdram_dout_i,
		.sdram_addr_o, .sdram_din_o, .sdram_we_o, .sdram_oe_o, .sdram_ds_o, .c16_din_o
	);

endmodule

// ==== tb_c16_mem_glue.sv ====
/* testbench for the C16 memory glue with a behavioral SDRAM behind the request port
   I/O controller bytes are spaced 42 cycles apart, more than one slice pair */
module tb_c16_mem_glue import c16_mem_pkg::*, c16_io_pkg::*;;

	localparam int RST_LONG  = 300;
	localparam int RST_SHORT = 40;
	localparam int BYTE_GAP  = 40;
	// reset, mapping, PRG, two ROM images, TAP with playback, plus margin
	localparam int WATCHDOG_CYCLES = (RST_LONG + 100) + 60 * 16 + 3 * (RST_SHORT + 20) +
		4 * 42 * (BYTE_GAP + 2) + 8 * 16 + 28 * 40 + 400 + 2000;

	logic        clk28 = 1'b0;
	logic        pll_locked;
	logic        c16_ras_i, c16_cas_i, c16_rw_i;
	logic [7:0]  c16_a_i, c16_dout_i, c16_din_o;
	logic        c16_basic_sel_i, c16_kernal_sel_i, c16_wait_o;
	logic [13:0] c16_rom_addr_i;
	logic [3:0]  c16_rom_sel_i;
	logic        ioctl_download_i, ioctl_wr_i;
	logic [7:0]  ioctl_index_i, ioctl_data_i;
	dl_addr_t    ioctl_addr_i;
	logic        io_reboot_i, reset_req_i, memory_16k_i;
	word_addr_t  sdram_addr_o;
	logic [15:0] sdram_din_o;
	logic [15:0] sdram_dout_i = '0;
	logic        sdram_we_o, sdram_oe_o, clkref_o;
	logic [1:0]  sdram_ds_o, tap_version_o;
	logic        tap_wrfull_i, tap_wrreq_o, tap_reset_o, reset_o;
	logic [7:0]  tap_data_o;

	int          errors = 0;
	int          checks = 0;
	logic [31:0] lfsr = 32'h5aca;
	logic [15:0] mem [word_addr_t];
	logic [7:0]  stream [$];
	logic [7:0]  tap_exp [$];
	int          tap_got = 0;
	// values sampled by the bus driver in the C16 slice
	word_addr_t  got_addr;
	logic        got_we, got_oe, got_ref;
	logic [1:0]  got_ds;
	logic [7:0]  got_din;

	c16_mem_glue #(.RESET_LONG(RST_LONG), .RESET_SHORT(RST_SHORT)) DUT (.*);

	always #20 clk28 = ~clk28;

	// ------------------------------------------------------------------------
	// SDRAM model with read data one cycle after the address
	// ------------------------------------------------------------------------
	always @(posedge clk28) begin
		if (sdram_we_o) begin
			if (!mem.exists(sdram_addr_o))
				mem[sdram_addr_o] = 16'h0000;
			if (sdram_ds_o[0])
				mem[sdram_addr_o][7:0] = sdram_din_o[7:0];
			if (sdram_ds_o[1])
				mem[sdram_addr_o][15:8] = sdram_din_o[15:8];
		end
		sdram_dout_i <= mem.exists(sdram_addr_o) ? mem[sdram_addr_o] : 16'h0000;
	end

	// galois LFSR stepped once per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
			r = {r[30:0], lfsr[0]};
		end
		return r;
	endfunction

	function automatic word_addr_t ref_word_addr(input logic rom, input rom_bank_t bank,
		input logic [13:0] ra, input cpu_addr_t a, input logic m16k);
		if (rom)
			return {8'd0, 1'b1, bank, ra[13:1]};
		else if (m16k)
			return {9'd0, 1'b0, a[13:7], 1'b0, a[6:1]};
		return {9'd0, a[15:1]};
	endfunction

	// BASIC pointers hold the download end address plus one
	function automatic logic [15:0] ref_end_ptr(input logic [15:0] load, input int len);
		return load + len[15:0] + 16'd1;
	endfunction

	function automatic logic [7:0] mem_byte(input dl_addr_t b);
		logic [15:0] w;
		w = mem.exists(b[24:1]) ? mem[b[24:1]] : 16'h0000;
		return b[0] ? w[15:8] : w[7:0];
	endfunction

	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("[ERROR] %s: got %h, expected %h at %0t", name, got, exp, $time);
		end
	endtask

	// tape bytes must come out in download order
	always @(negedge clk28) begin
		if (tap_wrreq_o) begin
			checks++;
			assert (tap_exp.size() != 0) else begin
				errors++;
				$display("tape byte %h delivered when none was expected", tap_data_o);
			end
			if (tap_exp.size() != 0)
				check_value("tap_data_o", tap_data_o, tap_exp.pop_front());
			tap_got++;
		end
	end

	// one RAS/CAS cycle of 16 clocks sampled one cycle after the address is complete
	task automatic bus_cycle(input cpu_addr_t a, input logic rw, input logic [7:0] d,
		input logic basic, input logic kernal, input logic [3:0] rsel, input logic [13:0] ra);
		@(negedge clk28);
		c16_ras_i = 1'b0;
		c16_a_i   = a[7:0];
		repeat (8) @(negedge clk28);
		c16_cas_i        = 1'b0;
		c16_a_i          = a[15:8];
		c16_rw_i         = rw;
		c16_dout_i       = d;
		c16_basic_sel_i  = basic;
		c16_kernal_sel_i = kernal;
		c16_rom_sel_i    = rsel;
		c16_rom_addr_i   = ra;
		repeat (2) @(negedge clk28);
		got_addr = sdram_addr_o;
		got_we   = sdram_we_o;
		got_oe   = sdram_oe_o;
		got_ds   = sdram_ds_o;
		got_din  = c16_din_o;
		got_ref  = clkref_o;
		repeat (3) @(negedge clk28);
		c16_cas_i        = 1'b1;
		c16_ras_i        = 1'b1;
		c16_rw_i         = 1'b1;
		c16_basic_sel_i  = 1'b1;
		c16_kernal_sel_i = 1'b1;
		repeat (2) @(negedge clk28);
	endtask

	task automatic check_mapping(input cpu_addr_t a, input logic rw, input logic rom,
		input rom_bank_t bank, input logic [13:0] ra);
		logic basic;
		logic [3:0] rsel;
		logic d0;
		basic = !(bank == 2'b01 || bank == 2'b10);
		rsel  = (bank == 2'b11) ? 4'b1000 : ((bank == 2'b10) ? 4'b0010 : 4'b0000);
		bus_cycle(a, rw, rand_bits(8), rom ? basic : 1'b1, rom ? !basic : 1'b1, rsel, ra);
		d0 = rom ? ra[0] : a[0];
		check_value("clkref_o", got_ref, 1'b1);
		check_value("sdram_addr_o", got_addr, ref_word_addr(rom, bank, ra, a, memory_16k_i));
		check_value("sdram_we_o", got_we, !rom && !rw);
		check_value("sdram_oe_o", got_oe, rom || rw);
		check_value("sdram_ds_o", got_ds, {d0, !d0});
	endtask

	// counts the cycles reset_o stays high from the current edge
	task automatic measure_reset(input int exp);
		int n;
		n = 0;
		while (reset_o && n < exp + 10) begin
			checks++;
			assert (!sdram_we_o && !sdram_oe_o && !tap_wrreq_o && !c16_wait_o && tap_reset_o)
			else begin
				errors++;
				$display("a control output was active during reset at %0t", $time);
			end
			@(negedge clk28);
			n++;
		end
		checks++;
		assert (n >= exp - 1 && n <= exp + 1) else begin
			errors++;
			$display("[ERROR] reset_o cycles high: got %h, expected %h", n, exp);
		end
	endtask

	task automatic run_download(input logic [7:0] idx, input dl_addr_t first, input logic wait_exp);
		@(negedge clk28);
		ioctl_download_i = 1'b1;
		ioctl_index_i    = idx;
		foreach (stream[i]) begin
			@(negedge clk28);
			ioctl_wr_i   = 1'b1;
			ioctl_addr_i = first + i;
			ioctl_data_i = stream[i];
			@(negedge clk28);
			ioctl_wr_i = 1'b0;
			repeat (BYTE_GAP) begin
				@(negedge clk28);
				check_value("c16_wait_o", c16_wait_o, wait_exp);
			end
		end
		ioctl_download_i = 1'b0;
		@(negedge clk28);
	endtask

	task automatic fill_stream(input int len);
		stream.delete();
		for (int i = 0; i < len; i++)
			stream.push_back(rand_bits(8));
	endtask

	// ------------------------------------------------------------------------
	// main sequence
	// ------------------------------------------------------------------------
	initial begin
		logic [15:0] load;
		int len;
		logic [7:0] wb;
		int held;
		pll_locked = 1'b0;
		{c16_ras_i, c16_cas_i, c16_rw_i, c16_basic_sel_i, c16_kernal_sel_i} = 5'b11111;
		c16_a_i = '0;
		c16_dout_i = '0;
		c16_rom_addr_i = '0;
		c16_rom_sel_i = '0;
		ioctl_download_i = 1'b0;
		ioctl_wr_i = 1'b0;
		ioctl_index_i = '0;
		ioctl_data_i = '0;
		ioctl_addr_i = '0;
		io_reboot_i = 1'b0;
		reset_req_i = 1'b0;
		memory_16k_i = 1'b0;
		tap_wrfull_i = 1'b0;
		repeat (8) @(negedge clk28);
		pll_locked = 1'b1;
		measure_reset(RST_LONG);

		// C16 mapping in both layouts and for each ROM bank
		for (int i = 0; i < 20; i++)
			check_mapping(rand_bits(16), rand_bits(1), 1'b0, 2'b00, '0);
		@(negedge clk28);
		memory_16k_i = 1'b1;
		repeat (2) @(negedge clk28);
		measure_reset(RST_SHORT);
		for (int i = 0; i < 20; i++)
			check_mapping(rand_bits(16), rand_bits(1), 1'b0, 2'b00, '0);
		for (int i = 0; i < 12; i++)
			check_mapping(rand_bits(16), 1'b1, 1'b1, i % 4, rand_bits(14));
		@(negedge clk28);
		memory_16k_i = 1'b0;
		repeat (2) @(negedge clk28);
		measure_reset(RST_SHORT);

		// PRG injection and the pointer shadow
		load = 16'h1000 + rand_bits(12);
		len  = 8 + rand_bits(5);
		fill_stream(len + 2);
		stream[0] = load[7:0];
		stream[1] = load[15:8];
		run_download(IDX_PRG, '0, 1'b1);
		for (int i = 0; i < len; i++)
			check_value("prg byte", mem_byte(load + i), stream[i + 2]);
		repeat (4) @(negedge clk28);
		// program bytes read back through both SDRAM lanes
		bus_cycle(load, 1'b1, 8'h00, 1'b1, 1'b1, 4'h0, '0);
		check_value("c16_din_o", got_din, stream[2]);
		bus_cycle(load + 16'd1, 1'b1, 8'h00, 1'b1, 1'b1, 4'h0, '0);
		check_value("c16_din_o", got_din, stream[3]);
		bus_cycle(16'h002d, 1'b1, 8'h00, 1'b1, 1'b1, 4'h0, '0);
		check_value("c16_din_o", got_din, ref_end_ptr(load, len) & 16'h00ff);
		bus_cycle(16'h002e, 1'b1, 8'h00, 1'b1, 1'b1, 4'h0, '0);
		check_value("c16_din_o", got_din, ref_end_ptr(load, len) >> 8);
		bus_cycle(16'h009d, 1'b1, 8'h00, 1'b1, 1'b1, 4'h0, '0);
		check_value("c16_din_o", got_din, ref_end_ptr(load, len) & 16'h00ff);
		bus_cycle(16'h009e, 1'b1, 8'h00, 1'b1, 1'b1, 4'h0, '0);
		check_value("c16_din_o", got_din, ref_end_ptr(load, len) >> 8);
		wb = rand_bits(8);
		bus_cycle(16'h002f, 1'b0, wb, 1'b1, 1'b1, 4'h0, '0);
		bus_cycle(16'h002f, 1'b1, 8'h00, 1'b1, 1'b1, 4'h0, '0);
		check_value("c16_din_o", got_din, wb);

		// index 3 image from byte 0
		fill_stream(16 + rand_bits(3));
		run_download(IDX_ROM3, '0, 1'b1);
		measure_reset(RST_SHORT);
		foreach (stream[i])
			check_value("rom3 byte", mem_byte(ROM_MEM_START + i), stream[i]);

		// index 0 image whose 3 bytes below the skip point are dropped
		fill_stream(15 + rand_bits(3));
		run_download(IDX_ROM0, ROM0_SKIP - 3, 1'b1);
		measure_reset(RST_SHORT);
		for (int i = 3; i < stream.size(); i++)
			check_value("rom0 byte", mem_byte(ROM_MEM_START + i - 3), stream[i]);

		// TAP download and playback with a pause from the player FIFO
		fill_stream(20 + rand_bits(3));
		foreach (stream[i])
			tap_exp.push_back(stream[i]);
		run_download(IDX_TAP, '0, 1'b0);
		check_value("tap_version_o", tap_version_o, stream[TAP_VERSION_OFFSET][1:0]);
		for (int n = 0; n < 2000 && tap_got < 5; n++)
			@(negedge clk28);
		tap_wrfull_i = 1'b1;
		// a fetch already in flight may still finish
		repeat (20) @(negedge clk28);
		held = tap_got;
		repeat (180) @(negedge clk28);
		check_value("tap_wrreq_o count", tap_got, held);
		tap_wrfull_i = 1'b0;
		for (int n = 0; n < 2000 && tap_got < stream.size(); n++)
			@(negedge clk28);
		repeat (100) @(negedge clk28);
		check_value("tap bytes delivered", tap_got, stream.size());

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

	// watchdog
	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk28);
		$display("simulation timed out after %0d cycles", WATCHDOG_CYCLES);
		$display("Finished with errors");
		$finish;
	end

endmodule

// ==== sources.f ====
c16_mem_pkg.sv
c16_io_pkg.sv
c16_bus_if.sv
dl_if.sv
c16_bus_decode.sv
reset_gen.sv
prg_injector.sv
zp_shadow.sv
tap_fetcher.sv
sdram_arbiter.sv
c16_mem_glue.sv
tb_c16_mem_glue.sv
